//--- rtl/patbuf_cfg_pkg.sv
`default_nettype none

// sizes and storage types of the pattern buffer array
package patbuf_cfg_pkg;

	// one pattern byte and the number of bytes in a buffer
	localparam int field_width = 8;
	localparam int fields_per_buf = 16;

	// tweak channels and the widths of their packed fields
	localparam int tweak_count = 6;
	localparam int delay_width = 3;
	localparam int duration_width = 2;

	typedef logic [field_width-1:0] field_t;
	typedef logic [$clog2(fields_per_buf)-1:0] field_ptr_t;

	// a whole buffer, as seen by the drive decoder
	typedef field_t buf_fields_t [fields_per_buf];

	typedef logic [delay_width-1:0] delay_t;
	typedef logic [duration_width-1:0] duration_t;

endpackage

`default_nettype wire

//--- rtl/patbuf_map_pkg.sv
`default_nettype none

// layout of the fields inside one pattern buffer
package patbuf_map_pkg;

	// ************************************************************************
	// field offsets, high phase in 0..7, low phase in 8..15
	// ************************************************************************

	localparam int pdrive_fld = 0;
	localparam int ptweak_delay_fld = 1;
	// tweak channel k sits at base + k
	localparam int ptweak_base_fld = 2;

	localparam int ndrive_fld = 8;
	localparam int ntweak_delay_fld = 9;
	localparam int ntweak_base_fld = 10;

	// ************************************************************************
	// bit positions inside a tweak byte
	// ************************************************************************

	localparam int tweak_enable_bit = 0;
	// delay occupies bits 3:1
	localparam int tweak_delay_lsb = 1;
	// duration occupies bits 5:4
	localparam int tweak_duration_lsb = 4;
	localparam int tweak_sense_bit = 6;

endpackage

`default_nettype wire

//--- rtl/pattern_store.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_store #(
	parameter int no_bufs = 8
) (
	input logic clk,
	input logic rst,

	// host write port
	input logic field_write_in,
	input logic [$clog2(no_bufs)-1:0] bufp_in,
	input patbuf_cfg_pkg::field_ptr_t fieldwp_in,
	input patbuf_cfg_pkg::field_t field_in_in,

	// host readback
	input patbuf_cfg_pkg::field_ptr_t fieldp_in,
	output patbuf_cfg_pkg::field_t field_byte_out,

	// buffer read-out for the drive decoder
	input logic [no_bufs-1:0] buf_sel,
	output patbuf_cfg_pkg::buf_fields_t cur_fields
);

	import patbuf_cfg_pkg::*;

	localparam int bufp_width = $clog2(no_bufs);

	buf_fields_t mem [no_bufs];

	// registered host request
	logic field_write;
	logic [bufp_width-1:0] bufp;
	field_ptr_t fieldwp;
	field_ptr_t fieldp;
	field_t field_in;

	// ************************************************************************
	// host side, pointers sampled first, array accessed one edge later
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			field_write <= 1'b0;
		end else begin
			field_write <= field_write_in;
		end
	end

	// bufp is shared by the read and the write path
	always_ff @(posedge clk) begin
		bufp <= bufp_in;
		fieldwp <= fieldwp_in;
		fieldp <= fieldp_in;
		field_in <= field_in_in;
	end

	always_ff @(posedge clk) begin
		if (field_write) begin
			mem[bufp][fieldwp] <= field_in;
		end
	end

	// readback shows the old byte if a write lands on the same edge
	always_ff @(posedge clk) begin
		field_byte_out <= mem[bufp][fieldp];
	end

	// ************************************************************************
	// buffer read-out, and-or mux on the one-hot select
	// ************************************************************************

	always_comb begin
		for (int f = 0; f < fields_per_buf; f++) begin
			cur_fields[f] = '0;
			for (int b = 0; b < no_bufs; b++) begin
				cur_fields[f] = cur_fields[f] | (mem[b][f] & {field_width{buf_sel[b]}});
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/phase_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sequencer #(
	parameter int no_bufs = 8
) (
	input logic clk,
	input logic rst,
	input logic pwm,
	output logic phase_high,
	output logic drive_off,
	output logic [no_bufs-1:0] buf_sel
);

	logic pwm_change;
	logic walk_done;

	// phase_high is the previous pwm sample
	assign pwm_change = pwm != phase_high;
	assign walk_done = buf_sel[no_bufs-1];

	always_ff @(posedge clk) begin
		phase_high <= pwm;
	end

	// ************************************************************************
	// dead time and one-hot buffer walk
	// ************************************************************************

	// a pwm change restarts the sequence even in the middle of a walk
	always_ff @(posedge clk) begin
		if (rst) begin
			drive_off <= 1'b1;
			buf_sel <= {{(no_bufs-1){1'b0}}, 1'b1};
		end else if (pwm_change) begin
			drive_off <= 1'b1;
		end else if (drive_off) begin
			// one dead cycle, then start at buffer 0
			drive_off <= 1'b0;
			buf_sel <= {{(no_bufs-1){1'b0}}, 1'b1};
		end else if (!walk_done) begin
			buf_sel <= buf_sel << 1;
		end
		// last buffer is held until the next change
	end

endmodule

`default_nettype wire

//--- rtl/drive_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module drive_decoder (
	input logic clk,
	input logic rst,
	input logic phase_high,
	input logic drive_off,
	input patbuf_cfg_pkg::buf_fields_t cur_fields,

	// gate drives
	output patbuf_cfg_pkg::field_t p_drive,
	output patbuf_cfg_pkg::field_t n_drive,

	// tweak controls
	output patbuf_cfg_pkg::field_t tweak_global_delay,
	output logic [patbuf_cfg_pkg::tweak_count-1:0] tweak_enable,
	output logic [patbuf_cfg_pkg::tweak_count-1:0] tweak_sense,
	output patbuf_cfg_pkg::delay_t tweak_delay [patbuf_cfg_pkg::tweak_count],
	output patbuf_cfg_pkg::duration_t tweak_duration [patbuf_cfg_pkg::tweak_count]
);

	import patbuf_cfg_pkg::*;
	import patbuf_map_pkg::*;

	// bytes of the active phase
	field_t p_src;
	field_t n_src;
	field_t gdelay_src;
	field_t tweak_byte [tweak_count];

	// ************************************************************************
	// phase selection
	// ************************************************************************

	// the idle drive is all ones on p and all zeros on n
	always_comb begin
		if (phase_high) begin
			p_src = cur_fields[pdrive_fld];
			n_src = '0;
			gdelay_src = cur_fields[ptweak_delay_fld];
		end else begin
			p_src = {field_width{1'b1}};
			n_src = cur_fields[ndrive_fld];
			gdelay_src = cur_fields[ntweak_delay_fld];
		end
	end

	always_comb begin
		for (int k = 0; k < tweak_count; k++) begin
			if (phase_high) begin
				tweak_byte[k] = cur_fields[ptweak_base_fld + k];
			end else begin
				tweak_byte[k] = cur_fields[ntweak_base_fld + k];
			end
		end
	end

	// ************************************************************************
	// output registers
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			p_drive <= {field_width{1'b1}};
			n_drive <= '0;
			tweak_global_delay <= '0;
			tweak_enable <= '0;
			tweak_sense <= '0;
			for (int k = 0; k < tweak_count; k++) begin
				tweak_delay[k] <= '0;
				tweak_duration[k] <= '0;
			end
		end else if (drive_off) begin
			// dead time, drives off and tweaks disabled
			// delays, durations and senses keep their values
			p_drive <= {field_width{1'b1}};
			n_drive <= '0;
			tweak_enable <= '0;
		end else begin
			p_drive <= p_src;
			n_drive <= n_src;
			tweak_global_delay <= gdelay_src;
			for (int k = 0; k < tweak_count; k++) begin
				tweak_enable[k] <= tweak_byte[k][tweak_enable_bit];
				tweak_sense[k] <= tweak_byte[k][tweak_sense_bit];
				tweak_delay[k] <= tweak_byte[k][tweak_delay_lsb +: delay_width];
				tweak_duration[k] <= tweak_byte[k][tweak_duration_lsb +: duration_width];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/pattern_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_buffer_top #(
	parameter int no_bufs = 8
) (
	input logic clk,
	input logic rst,
	input logic pwm,

	// host port
	input logic field_write_in,
	input logic [$clog2(no_bufs)-1:0] bufp_in,
	input patbuf_cfg_pkg::field_ptr_t fieldwp_in,
	input patbuf_cfg_pkg::field_ptr_t fieldp_in,
	input patbuf_cfg_pkg::field_t field_in_in,
	output patbuf_cfg_pkg::field_t field_byte_out,

	// driver outputs
	output patbuf_cfg_pkg::field_t p_drive,
	output patbuf_cfg_pkg::field_t n_drive,
	output patbuf_cfg_pkg::field_t tweak_global_delay,
	output logic [patbuf_cfg_pkg::tweak_count-1:0] tweak_enable,
	output logic [patbuf_cfg_pkg::tweak_count-1:0] tweak_sense,
	output patbuf_cfg_pkg::delay_t tweak_delay [patbuf_cfg_pkg::tweak_count],
	output patbuf_cfg_pkg::duration_t tweak_duration [patbuf_cfg_pkg::tweak_count]
);

	import patbuf_cfg_pkg::*;

	logic [no_bufs-1:0] buf_sel;
	buf_fields_t cur_fields;
	logic phase_high;
	logic drive_off;

	pattern_store #(
		.no_bufs(no_bufs)
	) u_store (
		.clk(clk),
		.rst(rst),
		.field_write_in(field_write_in),
		.bufp_in(bufp_in),
		.fieldwp_in(fieldwp_in),
		.field_in_in(field_in_in),
		.fieldp_in(fieldp_in),
		.field_byte_out(field_byte_out),
		.buf_sel(buf_sel),
		.cur_fields(cur_fields)
	);

	phase_sequencer #(
		.no_bufs(no_bufs)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.pwm(pwm),
		.phase_high(phase_high),
		.drive_off(drive_off),
		.buf_sel(buf_sel)
	);

	drive_decoder u_decode (
		.clk(clk),
		.rst(rst),
		.phase_high(phase_high),
		.drive_off(drive_off),
		.cur_fields(cur_fields),
		.p_drive(p_drive),
		.n_drive(n_drive),
		.tweak_global_delay(tweak_global_delay),
		.tweak_enable(tweak_enable),
		.tweak_sense(tweak_sense),
		.tweak_delay(tweak_delay),
		.tweak_duration(tweak_duration)
	);

endmodule

`default_nettype wire

//--- bench/pattern_buffer_props.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_buffer_props #(
	parameter int no_bufs = 8
) (
	input logic clk,
	input logic rst,
	input logic drive_off,
	input logic [no_bufs-1:0] buf_sel,
	input patbuf_cfg_pkg::field_t p_drive,
	input patbuf_cfg_pkg::field_t n_drive,
	input logic [patbuf_cfg_pkg::tweak_count-1:0] tweak_enable
);

	import patbuf_cfg_pkg::*;

	// never both drives on at once
	drives_exclusive: assert property (@(posedge clk) disable iff (rst)
		(n_drive != '0) |-> (p_drive == {field_width{1'b1}}))
		else $error("n_drive active while p_drive is not all ones");

	walk_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(buf_sel))
		else $error("buf_sel is not one-hot");

	// dead time disables every tweak channel
	dead_time_tweaks: assert property (@(posedge clk) disable iff (rst)
		drive_off |=> (tweak_enable == '0))
		else $error("tweak_enable not cleared after drive_off");

endmodule

bind pattern_buffer_top pattern_buffer_props #(.no_bufs(no_bufs)) u_props (
	.clk(clk),
	.rst(rst),
	.drive_off(drive_off),
	.buf_sel(buf_sel),
	.p_drive(p_drive),
	.n_drive(n_drive),
	.tweak_enable(tweak_enable)
);

`default_nettype wire

//--- bench/pattern_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_buffer_tb;

	import patbuf_cfg_pkg::*;
	import patbuf_map_pkg::*;

	localparam int no_bufs = 8;
	localparam int clk_period = 10;
	// reset, fill, readback, reset start, three walks, toggle, rewrite
	localparam int test_cycles = 16 + 130 + 132 + 30 + 3 * 16 + 22 + 30;
	localparam int timeout_cycles = 2 * test_cycles + 200;

	typedef struct packed {
		field_t p_drive;
		field_t n_drive;
		field_t gdelay;
		logic [tweak_count-1:0] enable;
		logic [tweak_count-1:0] sense;
		logic [tweak_count*delay_width-1:0] delay;
		logic [tweak_count*duration_width-1:0] duration;
	} exp_t;

	logic clk;
	logic rst;
	logic pwm;
	logic field_write_in;
	logic [$clog2(no_bufs)-1:0] bufp_in;
	field_ptr_t fieldwp_in;
	field_ptr_t fieldp_in;
	field_t field_in_in;
	field_t field_byte_out;
	field_t p_drive;
	field_t n_drive;
	field_t tweak_global_delay;
	logic [tweak_count-1:0] tweak_enable;
	logic [tweak_count-1:0] tweak_sense;
	delay_t tweak_delay [tweak_count];
	duration_t tweak_duration [tweak_count];

	field_t shadow [no_bufs][fields_per_buf];
	exp_t exp_state;
	logic check_en;
	logic [31:0] rng_state;
	int error_count;
	int test_errors;
	int test_num;

	pattern_buffer_top #(
		.no_bufs(no_bufs)
	) UUT (
		.clk(clk),
		.rst(rst),
		.pwm(pwm),
		.field_write_in(field_write_in),
		.bufp_in(bufp_in),
		.fieldwp_in(fieldwp_in),
		.fieldp_in(fieldp_in),
		.field_in_in(field_in_in),
		.field_byte_out(field_byte_out),
		.p_drive(p_drive),
		.n_drive(n_drive),
		.tweak_global_delay(tweak_global_delay),
		.tweak_enable(tweak_enable),
		.tweak_sense(tweak_sense),
		.tweak_delay(tweak_delay),
		.tweak_duration(tweak_duration)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int next_buf(input int b);
		return (b < no_bufs - 1) ? b + 1 : b;
	endfunction

	// ************************************************************************
	// expected outputs for one buffer and phase, or for the dead cycle
	// ************************************************************************

	function automatic exp_t ref_outputs(input field_t mem [no_bufs][fields_per_buf],
			input exp_t prev, input bit off, input bit high, input int b);
		exp_t r;
		int base;
		field_t tbyte;
		r = prev;
		r.p_drive = '1;
		r.n_drive = '0;
		if (off) begin
			// delays, durations and senses hold
			r.enable = '0;
			return r;
		end
		if (high) begin
			r.p_drive = mem[b][pdrive_fld];
			r.gdelay = mem[b][ptweak_delay_fld];
			base = ptweak_base_fld;
		end else begin
			r.n_drive = mem[b][ndrive_fld];
			r.gdelay = mem[b][ntweak_delay_fld];
			base = ntweak_base_fld;
		end
		for (int k = 0; k < tweak_count; k++) begin
			tbyte = mem[b][base + k];
			r.enable[k] = tbyte[tweak_enable_bit];
			r.sense[k] = tbyte[tweak_sense_bit];
			r.delay[k*delay_width +: delay_width] = tbyte[tweak_delay_lsb +: delay_width];
			r.duration[k*duration_width +: duration_width] =
				tbyte[tweak_duration_lsb +: duration_width];
		end
		return r;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	// outputs are stable half a cycle after the edge
	always @(negedge clk) begin : compare_outputs
		logic [tweak_count*delay_width-1:0] act_delay;
		logic [tweak_count*duration_width-1:0] act_duration;
		if (check_en) begin
			for (int k = 0; k < tweak_count; k++) begin
				act_delay[k*delay_width +: delay_width] = tweak_delay[k];
				act_duration[k*duration_width +: duration_width] = tweak_duration[k];
			end
			compare_value("p_drive", exp_state.p_drive, p_drive);
			compare_value("n_drive", exp_state.n_drive, n_drive);
			compare_value("tweak_global_delay", exp_state.gdelay, tweak_global_delay);
			compare_value("tweak_enable", exp_state.enable, tweak_enable);
			compare_value("tweak_sense", exp_state.sense, tweak_sense);
			compare_value("tweak_delay", exp_state.delay, act_delay);
			compare_value("tweak_duration", exp_state.duration, act_duration);
		end
	end

	task automatic start_test();
		test_num++;
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s, %0d errors", test_num, name,
			(test_errors == 0) ? "ok" : "wrong", test_errors);
	endtask

	task automatic set_expect(input bit off, input bit high, input int b);
		exp_state = ref_outputs(shadow, exp_state, off, high, b);
		check_en = 1'b1;
	endtask

	task automatic write_byte(input int b, input int f, input field_t d);
		@(posedge clk);
		field_write_in <= 1'b1;
		bufp_in <= b;
		fieldwp_in <= f;
		field_in_in <= d;
		shadow[b][f] = d;
	endtask

	task automatic hold_last(input int n, input bit high);
		repeat (n) begin
			@(posedge clk);
			set_expect(0, high, no_bufs - 1);
		end
	endtask

	// pwm changes on the current edge, prev_buf is the buffer shown on it
	task automatic run_phase(input bit high, input int last_buf, input bit prev_high,
			input int prev_buf);
		pwm <= high;
		@(posedge clk);
		set_expect(0, prev_high, next_buf(prev_buf));
		@(posedge clk);
		set_expect(1, high, 0);
		for (int k = 0; k <= last_buf; k++) begin
			@(posedge clk);
			set_expect(0, high, k);
		end
	endtask

	// ************************************************************************
	// test sequence
	// ************************************************************************

	initial begin
		field_t d;
		clk = 1'b0;
		rst = 1'b1;
		pwm = 1'b0;
		field_write_in = 1'b0;
		bufp_in = '0;
		fieldwp_in = '0;
		fieldp_in = '0;
		field_in_in = '0;
		check_en = 1'b0;
		rng_state = 32'hf840;
		error_count = 0;
		test_num = 0;
		exp_state = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		start_test();
		for (int i = 0; i < no_bufs * fields_per_buf; i++) begin
			rng_state = lcg_next(rng_state);
			d = rng_state[23:16];
			write_byte(i / fields_per_buf, i % fields_per_buf, d);
		end
		@(posedge clk);
		field_write_in <= 1'b0;
		// read pointers of index i show up two edges later
		for (int i = 0; i < no_bufs * fields_per_buf + 2; i++) begin
			@(posedge clk);
			if (i < no_bufs * fields_per_buf) begin
				bufp_in <= i / fields_per_buf;
				fieldp_in <= i % fields_per_buf;
			end
			@(negedge clk);
			if (i >= 2) begin
				compare_value("field_byte_out",
					shadow[(i - 2) / fields_per_buf][(i - 2) % fields_per_buf],
					field_byte_out);
			end
		end
		@(posedge clk);
		end_test("fill and readback");

		start_test();
		rst <= 1'b1;
		pwm <= 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		exp_state = '0;
		exp_state.p_drive = '1;
		@(posedge clk);
		set_expect(1, 0, 0);
		for (int k = 0; k < no_bufs; k++) begin
			@(posedge clk);
			set_expect(0, 0, k);
		end
		hold_last(2, 0);
		end_test("reset start");

		start_test();
		run_phase(1, no_bufs - 1, 0, no_bufs - 1);
		hold_last(4, 1);
		end_test("high phase walk");

		start_test();
		run_phase(0, no_bufs - 1, 1, no_bufs - 1);
		hold_last(4, 0);
		end_test("low phase walk");

		start_test();
		run_phase(1, 3, 0, no_bufs - 1);
		run_phase(0, no_bufs - 1, 1, 3);
		hold_last(2, 0);
		end_test("toggle mid walk");

		start_test();
		run_phase(1, no_bufs - 1, 0, no_bufs - 1);
		hold_last(2, 1);
		check_en = 1'b0;
		for (int f = 0; f < fields_per_buf / 2; f++) begin
			rng_state = lcg_next(rng_state);
			d = rng_state[23:16];
			write_byte(no_bufs - 1, f, d);
		end
		@(posedge clk);
		field_write_in <= 1'b0;
		repeat (4) @(posedge clk);
		hold_last(3, 1);
		end_test("rewrite held buffer");

		check_en = 1'b0;
		$display("tests run: %0d, errors: %0d", test_num, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(timeout_cycles * clk_period);
		$display("timeout: tests did not complete within %0d cycles", timeout_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- patbuf.f
rtl/patbuf_cfg_pkg.sv
rtl/patbuf_map_pkg.sv
rtl/pattern_store.sv
rtl/phase_sequencer.sv
rtl/drive_decoder.sv
rtl/pattern_buffer_top.sv
bench/pattern_buffer_props.sv
bench/pattern_buffer_tb.sv
